//--- verilog.f
common/lsu_pkg.sv
lsu/lsu_decode.sv
lsu/lsu_execute.sv
lsu/lsu_result.sv
logic/data_mem.sv
logic/lsu_top.sv
bench/tb_clock.sv
bench/lsu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?=
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- bench/lsu_tb.sv
// self-checking testbench of the load/store stage, table cases first, then random traffic
module lsu_tb
  import lsu_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT  = 100;
  localparam int RAND_OPS = 200;

  logic        clk;
  logic        reset_i;
  logic        req_valid_i;
  lsu_req_t    req_i;
  logic        req_ready_o;
  logic        resp_valid_o;
  lsu_resp_t   resp_o;
  string       tbl_name[$];
  lsu_req_t    tbl_req[$];
  lsu_resp_t   tbl_exp[$];
  word_t       mirror[16];  // random phase window at 0x400
  logic [31:0] rand_q;
  int          ops;
  int          value_errs;
  int          proto_errs;
  int          timeouts;
  logic        timed_out;

  tb_clock i_tb_clock (.clk_o(clk));

  lsu_top #(
    .MEM_WORDS (512),
    .MEM_DELAY (2)
  ) i_lsu_top (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  function automatic logic [31:0] next_random();
    rand_q ^= rand_q << 13;
    rand_q ^= rand_q >> 17;
    rand_q ^= rand_q << 5;
    return rand_q;
  endfunction

  // bytes of wdata land at off and up, the rest of old stays
  function automatic word_t merge_lanes(word_t old, word_t wdata, int off, int size);
    word_t w;
    w = old;
    for (int k = 0; k < size; k++) w[8*(off+k) +: 8] = wdata[8*k +: 8];
    return w;
  endfunction

  function automatic word_t extract_load(word_t dw, int off, int size, logic sgn);
    word_t v;
    v = '0;
    for (int k = 0; k < size; k++) v[8*k +: 8] = dw[8*(off+k) +: 8];
    if (sgn && v[8*size-1]) begin
      for (int k = size; k < 8; k++) v[8*k +: 8] = 8'hff;
    end
    return v;
  endfunction

  function automatic lsu_req_t make_req(logic st, logic [2:0] f3, word_t addr, word_t wdata);
    lsu_req_t r;
    r.is_store = st;
    r.funct3   = f3;
    r.addr     = addr;
    r.wdata    = wdata;
    return r;
  endfunction

  function automatic lsu_resp_t make_resp(lsu_fault_e fault, word_t rdata);
    lsu_resp_t r;
    r.fault = fault;
    r.rdata = rdata;
    return r;
  endfunction

  task automatic add_op(input string name, input logic st, input logic [2:0] f3,
                        input word_t addr, input word_t wdata, input lsu_fault_e fault,
                        input word_t rdata);
    tbl_name.push_back(name);
    tbl_req.push_back(make_req(st, f3, addr, wdata));
    tbl_exp.push_back(make_resp(fault, rdata));
  endtask

  task automatic check_fault(input string name, input lsu_fault_e exp, input lsu_fault_e act);
    if (act !== exp) begin
      $display("FAIL %s: fault expected %s, actual %s", name, exp.name(), act.name());
      value_errs++;
    end
  endtask

  task automatic check_data(input string name, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("FAIL %s: data expected %h, actual %h", name, exp, act);
      value_errs++;
    end
  endtask

  task automatic check_busy(input string name);
    if (req_ready_o) begin
      $display("req_ready_o went high while %s was still outstanding", name);
      proto_errs++;
    end
  endtask

  task automatic check_quiet(input string name);
    if (resp_valid_o) begin
      $display("response pulse without an outstanding request near %s", name);
      proto_errs++;
    end
  endtask

  task automatic stop_on_timeout(input string what, input string name);
    $display("timeout: %s never went high during %s", what, name);
    timeouts++;
    timed_out = 1'b1;
  endtask

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic run_op(input string name, input lsu_req_t req, input lsu_resp_t exp);
    int n;
    ops++;
    req_valid_i = 1'b1;
    req_i       = req;
    n = 0;
    while (!req_ready_o && n < TIMEOUT) begin
      check_quiet(name);
      step();
      n++;
    end
    if (!req_ready_o) begin
      stop_on_timeout("req_ready_o", name);
      return;
    end
    check_quiet(name);
    step(); // transfer on this edge
    req_valid_i = 1'b0;
    req_i       = lsu_req_t'(~req); // stage keeps its own copy
    n = 0;
    while (!resp_valid_o && n < TIMEOUT) begin
      check_busy(name);
      step();
      n++;
    end
    if (!resp_valid_o) begin
      stop_on_timeout("resp_valid_o", name);
      return;
    end
    check_busy(name);
    check_fault(name, exp.fault, resp_o.fault);
    check_data(name, exp.rdata, resp_o.rdata);
    if (exp.fault != FAULT_NONE && n != 1) begin
      $display("%s: fault response came %0d cycles after the transfer, not 1", name, n);
      proto_errs++;
    end
    step();
  endtask

  initial begin
    string       name;
    word_t       pat;
    word_t       bg;
    word_t       wd;
    word_t       v;
    logic [31:0] r;
    logic [1:0]  wsel;
    logic        st;
    logic        uns;
    int          size;
    int          off;
    int          idx;

    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_i       = '0;
    rand_q      = 32'hbe1f;
    ops         = 0;
    value_errs  = 0;
    proto_errs  = 0;
    timeouts    = 0;
    timed_out   = 1'b0;
    for (int i = 0; i < 16; i++) mirror[i] = '0;

    pat = 64'h0123_4567_89ab_cdef;
    add_op("sd round trip", 1'b1, 3'd3, 64'h100, pat, FAULT_NONE, 64'd0);
    add_op("ld round trip", 1'b0, 3'd3, 64'h100, 64'd0, FAULT_NONE, pat);

    // each lane store over a fresh background
    bg = 64'hf0e1_d2c3_b4a5_9687;
    wd = 64'h1122_3344_5566_7788;
    for (int w = 0; w < 3; w++) begin
      size = 1 << w;
      for (int o = 0; o < 8; o += size) begin
        name = $sformatf("lane size %0d offset %0d", size, o);
        add_op({name, " fill"}, 1'b1, 3'd3, 64'h200, bg, FAULT_NONE, 64'd0);
        add_op({name, " store"}, 1'b1, 3'(w), 64'h200 + word_t'(o), wd, FAULT_NONE, 64'd0);
        add_op({name, " check"}, 1'b0, 3'd3, 64'h200, 64'd0, FAULT_NONE,
               merge_lanes(bg, wd, o, size));
      end
    end

    add_op("sd sign pattern", 1'b1, 3'd3, 64'h300, 64'h9abc_def0_8765_43a1, FAULT_NONE, 64'd0);
    add_op("lb negative", 1'b0, 3'd0, 64'h300, 64'd0, FAULT_NONE, 64'hffff_ffff_ffff_ffa1);
    add_op("lbu", 1'b0, 3'd4, 64'h300, 64'd0, FAULT_NONE, 64'h0000_0000_0000_00a1);
    add_op("lb positive", 1'b0, 3'd0, 64'h301, 64'd0, FAULT_NONE, 64'h0000_0000_0000_0043);
    add_op("lh negative", 1'b0, 3'd1, 64'h306, 64'd0, FAULT_NONE, 64'hffff_ffff_ffff_9abc);
    add_op("lhu", 1'b0, 3'd5, 64'h306, 64'd0, FAULT_NONE, 64'h0000_0000_0000_9abc);
    add_op("lw negative", 1'b0, 3'd2, 64'h304, 64'd0, FAULT_NONE, 64'hffff_ffff_9abc_def0);
    add_op("lwu", 1'b0, 3'd6, 64'h304, 64'd0, FAULT_NONE, 64'h0000_0000_9abc_def0);
    add_op("lw low word", 1'b0, 3'd2, 64'h300, 64'd0, FAULT_NONE, 64'hffff_ffff_8765_43a1);

    // misaligned stores must leave 0x100 alone
    add_op("sh odd", 1'b1, 3'd1, 64'h101, 64'h0000_ffff, FAULT_MISALIGN, 64'd0);
    add_op("lh odd", 1'b0, 3'd1, 64'h107, 64'd0, FAULT_MISALIGN, 64'd0);
    add_op("sw offset 2", 1'b1, 3'd2, 64'h102, 64'hffff_ffff, FAULT_MISALIGN, 64'd0);
    add_op("lwu offset 6", 1'b0, 3'd6, 64'h106, 64'd0, FAULT_MISALIGN, 64'd0);
    add_op("sd offset 4", 1'b1, 3'd3, 64'h104, '1, FAULT_MISALIGN, 64'd0);
    add_op("ld offset 1", 1'b0, 3'd3, 64'h101, 64'd0, FAULT_MISALIGN, 64'd0);
    add_op("ld after misalign", 1'b0, 3'd3, 64'h100, 64'd0, FAULT_NONE, pat);

    add_op("load funct3 7", 1'b0, 3'd7, 64'h100, 64'd0, FAULT_ILLEGAL, 64'd0);
    for (int f = 4; f < 8; f++) begin
      add_op($sformatf("store funct3 %0d", f), 1'b1, 3'(f), 64'h100, 64'hdead_beef_dead_beef,
             FAULT_ILLEGAL, 64'd0);
    end
    add_op("ld after illegal", 1'b0, 3'd3, 64'h100, 64'd0, FAULT_NONE, pat);

    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;

    for (int i = 0; i < tbl_name.size() && !timed_out; i++) begin
      run_op(tbl_name[i], tbl_req[i], tbl_exp[i]);
    end

    for (int i = 0; i < RAND_OPS && !timed_out; i++) begin
      r    = next_random();
      st   = r[0];
      wsel = r[2:1];
      size = 1 << wsel;
      idx  = int'(r[7:4]);
      off  = int'(r[10:8]) & ~(size - 1); // natural alignment
      uns  = r[3] && !st && wsel != 2'd3;
      wd   = {next_random(), next_random()};
      if (st) begin
        mirror[idx] = merge_lanes(mirror[idx], wd, off, size);
        v = 64'd0;
      end else begin
        v = extract_load(mirror[idx], off, size, !uns);
      end
      run_op($sformatf("random %0d", i),
             make_req(st, {uns, wsel}, 64'h400 + word_t'(8 * idx + off), wd),
             make_resp(FAULT_NONE, v));
    end

    check_quiet("end of run");
    $display("%0d operations, %0d value errors, %0d protocol errors, %0d timeouts",
             ops, value_errs, proto_errs, timeouts);
    if (value_errs + proto_errs + timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/tb_clock.sv
// free-running clock for the load/store testbench, 4 ns period
module tb_clock (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

endmodule

//--- logic/lsu_top.sv
// load/store stage top level, joins sequencer, result stage and the data memory
module lsu_top
  import lsu_pkg::*;
#(
  parameter int MEM_WORDS = 512,
  parameter int MEM_DELAY = 2
) (
  input  logic      clk,
  input  logic      reset_i,
  input  logic      req_valid_i,
  input  lsu_req_t  req_i,
  output logic      req_ready_o,
  output logic      resp_valid_o,
  output lsu_resp_t resp_o
);

  lsu_dec_t dec;
  logic     done;
  logic     wr_valid;
  logic     wr_ready;
  mem_wr_t  wr;
  logic     wr_done_valid;
  logic     wr_done_ready;
  logic     rd_valid;
  logic     rd_ready;
  word_t    rd_addr;
  logic     rd_data_valid;
  logic     rd_data_ready;
  word_t    rd_data;

  lsu_execute i_lsu_execute (
    .clk             (clk),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_i           (req_i),
    .req_ready_o     (req_ready_o),
    .dec_o           (dec),
    .done_o          (done),
    .wr_valid_o      (wr_valid),
    .wr_o            (wr),
    .wr_ready_i      (wr_ready),
    .wr_done_valid_i (wr_done_valid),
    .wr_done_ready_o (wr_done_ready),
    .rd_valid_o      (rd_valid),
    .rd_addr_o       (rd_addr),
    .rd_ready_i      (rd_ready),
    .rd_data_valid_i (rd_data_valid),
    .rd_data_ready_o (rd_data_ready)
  );

  // raw doubleword goes straight to the result stage
  lsu_result i_lsu_result (
    .clk          (clk),
    .reset_i      (reset_i),
    .done_i       (done),
    .dec_i        (dec),
    .rd_data_i    (rd_data),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  data_mem #(
    .MEM_WORDS (MEM_WORDS),
    .MEM_DELAY (MEM_DELAY)
  ) i_data_mem (
    .clk             (clk),
    .reset_i         (reset_i),
    .wr_valid_i      (wr_valid),
    .wr_ready_o      (wr_ready),
    .wr_i            (wr),
    .wr_done_valid_o (wr_done_valid),
    .wr_done_ready_i (wr_done_ready),
    .rd_valid_i      (rd_valid),
    .rd_ready_o      (rd_ready),
    .rd_addr_i       (rd_addr),
    .rd_data_valid_o (rd_data_valid),
    .rd_data_o       (rd_data),
    .rd_data_ready_i (rd_data_ready)
  );

endmodule

//--- logic/data_mem.sv
// behavioral doubleword memory serving the write and read channels with a fixed delay
module data_mem
  import lsu_pkg::*;
#(
  parameter int MEM_WORDS = 512,
  parameter int MEM_DELAY = 2
) (
  input  logic    clk,
  input  logic    reset_i,
  input  logic    wr_valid_i,
  output logic    wr_ready_o,
  input  mem_wr_t wr_i,
  output logic    wr_done_valid_o,
  input  logic    wr_done_ready_i,
  input  logic    rd_valid_i,
  output logic    rd_ready_o,
  input  word_t   rd_addr_i,
  output logic    rd_data_valid_o,
  output word_t   rd_data_o,
  input  logic    rd_data_ready_i
);

  localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
  localparam int CNT_W = (MEM_DELAY > 1) ? $clog2(MEM_DELAY) : 1;

  word_t             mem_q [MEM_WORDS];
  word_t             rd_q;
  logic              busy_q;
  logic              is_rd_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [IDX_W-1:0]  wr_idx;
  logic [IDX_W-1:0]  rd_idx;
  logic              wr_acc;
  logic              rd_acc;
  logic              cpl;
  logic              release_hs;

  assign wr_idx = IDX_W'((wr_i.addr >> 3) % MEM_WORDS);
  assign rd_idx = IDX_W'((rd_addr_i >> 3) % MEM_WORDS);

  assign wr_ready_o = !busy_q;
  assign rd_ready_o = !busy_q && !wr_valid_i; // write wins a tie
  assign wr_acc     = wr_valid_i && wr_ready_o;
  assign rd_acc     = rd_valid_i && rd_ready_o;

  // completion held until taken
  assign cpl             = busy_q && cnt_q == '0;
  assign wr_done_valid_o = cpl && !is_rd_q;
  assign rd_data_valid_o = cpl && is_rd_q;
  assign rd_data_o       = rd_q;
  assign release_hs      = (wr_done_valid_o && wr_done_ready_i) ||
                           (rd_data_valid_o && rd_data_ready_i);

  always_ff @(posedge clk) begin
    if (reset_i) begin
      busy_q  <= 1'b0;
      is_rd_q <= 1'b0;
      cnt_q   <= '0;
      for (int i = 0; i < MEM_WORDS; i++) mem_q[i] <= '0;
    end else if (wr_acc) begin
      busy_q  <= 1'b1;
      is_rd_q <= 1'b0;
      cnt_q   <= CNT_W'(MEM_DELAY - 1);
      for (int b = 0; b < 8; b++) begin
        if (wr_i.mask[b]) mem_q[wr_idx][8*b +: 8] <= wr_i.data[8*b +: 8];
      end
    end else if (rd_acc) begin
      busy_q  <= 1'b1;
      is_rd_q <= 1'b1;
      cnt_q   <= CNT_W'(MEM_DELAY - 1);
      rd_q    <= mem_q[rd_idx]; // sampled on accept
    end else if (busy_q && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (release_hs) begin
      busy_q <= 1'b0;
    end
  end

endmodule

//--- lsu/lsu_result.sv
// aligns and extends load data and registers the one-cycle response of the stage
module lsu_result
  import lsu_pkg::*;
(
  input  logic      clk,
  input  logic      reset_i,
  input  logic      done_i,
  input  lsu_dec_t  dec_i,
  input  word_t     rd_data_i,
  output logic      resp_valid_o,
  output lsu_resp_t resp_o
);

  word_t     shifted;
  word_t     ext;
  logic      resp_valid_q;
  lsu_resp_t resp_q;

  assign shifted = rd_data_i >> {dec_i.offset, 3'b000};

  always_comb begin
    unique case (dec_i.width)
      W_BYTE: ext = dec_i.is_signed ? {{56{shifted[7]}}, shifted[7:0]} : {56'd0, shifted[7:0]};
      W_HALF: ext = dec_i.is_signed ? {{48{shifted[15]}}, shifted[15:0]} :
                                      {48'd0, shifted[15:0]};
      W_WORD: ext = dec_i.is_signed ? {{32{shifted[31]}}, shifted[31:0]} :
                                      {32'd0, shifted[31:0]};
      default: ext = shifted;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (done_i) begin
      resp_q.fault <= dec_i.fault;
      // stores and faults return zero
      resp_q.rdata <= (!dec_i.is_store && dec_i.fault == FAULT_NONE) ? ext : '0;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_o       = resp_q;

endmodule

//--- lsu/lsu_execute.sv
// bus sequencer of the load/store stage, captures one operation and runs its bus handshakes
module lsu_execute
  import lsu_pkg::*;
(
  input  logic     clk,
  input  logic     reset_i,
  input  logic     req_valid_i,
  input  lsu_req_t req_i,
  output logic     req_ready_o,
  output lsu_dec_t dec_o,
  output logic     done_o,
  output logic     wr_valid_o,
  output mem_wr_t  wr_o,
  input  logic     wr_ready_i,
  input  logic     wr_done_valid_i,
  output logic     wr_done_ready_o,
  output logic     rd_valid_o,
  output word_t    rd_addr_o,
  input  logic     rd_ready_i,
  input  logic     rd_data_valid_i,
  output logic     rd_data_ready_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQUEST,
    S_WAIT,
    S_RESPOND
  } state_e;

  state_e   state_q, state_d;
  lsu_req_t op_q;
  lsu_dec_t dec;
  logic     faulted;
  logic     req_hs;
  logic     cpl_hs;

  lsu_decode i_lsu_decode (
    .op_i  (op_q),
    .dec_o (dec)
  );

  assign faulted = dec.fault != FAULT_NONE;

  // bus side, driven from the state register
  assign wr_valid_o      = (state_q == S_REQUEST) && !faulted && dec.is_store;
  assign rd_valid_o      = (state_q == S_REQUEST) && !faulted && !dec.is_store;
  assign wr_done_ready_o = (state_q == S_WAIT) && dec.is_store;
  assign rd_data_ready_o = (state_q == S_WAIT) && !dec.is_store;

  assign wr_o.addr = dec.aligned_addr;
  assign wr_o.data = dec.lane_data;
  assign wr_o.mask = dec.lane_mask;
  assign rd_addr_o = dec.aligned_addr;

  assign req_hs = (wr_valid_o && wr_ready_i) || (rd_valid_o && rd_ready_i);
  assign cpl_hs = (wr_done_valid_i && wr_done_ready_o) ||
                  (rd_data_valid_i && rd_data_ready_o);

  assign req_ready_o = state_q == S_IDLE;
  assign done_o      = ((state_q == S_REQUEST) && faulted) || cpl_hs;
  assign dec_o       = dec;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      S_IDLE: begin
        if (req_valid_i) state_d = S_REQUEST;
      end
      S_REQUEST: begin
        if (faulted) begin
          state_d = S_RESPOND; // no bus access at all
        end else if (req_hs) begin
          state_d = S_WAIT;
        end
      end
      S_WAIT: begin
        if (cpl_hs) state_d = S_RESPOND;
      end
      default: state_d = S_IDLE; // response pulse goes out here
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state_q <= S_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid_i && req_ready_o) op_q <= req_i;
  end

endmodule

//--- lsu/lsu_decode.sv
// combinational decode of a captured load/store into lanes, width, sign and fault
module lsu_decode
  import lsu_pkg::*;
(
  input  lsu_req_t op_i,
  output lsu_dec_t dec_o
);

  lsu_width_e width;
  logic       illegal;
  logic       misalign;
  logic [2:0] offset;
  logic [7:0] size_mask;
  lsu_fault_e fault;

  assign width  = lsu_width_e'(op_i.funct3[1:0]);
  assign offset = op_i.addr[2:0];

  // stores stop at SD, loads stop at LWU
  assign illegal = op_i.is_store ? op_i.funct3[2] : (op_i.funct3 == 3'd7);

  always_comb begin
    misalign  = 1'b0;
    size_mask = 8'hff;
    unique case (width)
      W_BYTE: size_mask = 8'h01;
      W_HALF: begin
        size_mask = 8'h03;
        misalign  = offset[0];
      end
      W_WORD: begin
        size_mask = 8'h0f;
        misalign  = offset[1:0] != 2'b00;
      end
      default: misalign = offset != 3'b000;
    endcase
  end

  assign fault = illegal  ? FAULT_ILLEGAL  :
                 misalign ? FAULT_MISALIGN : FAULT_NONE;

  always_comb begin
    dec_o.is_store     = op_i.is_store;
    dec_o.width        = width;
    dec_o.is_signed    = ~op_i.funct3[2];
    dec_o.offset       = offset;
    dec_o.lane_mask    = (fault == FAULT_NONE) ? size_mask << offset : 8'h00;
    dec_o.aligned_addr = {op_i.addr[63:3], 3'b000};
    dec_o.lane_data    = op_i.wdata << {offset, 3'b000}; // into its byte lanes
    dec_o.fault        = fault;
  end

endmodule

//--- common/lsu_pkg.sv
// load/store stage types, imported by the stage modules, the data memory and the testbench
package lsu_pkg;

  typedef logic [63:0] word_t;

  // funct3[1:0] of the RISC-V load/store encoding
  typedef enum logic [1:0] {
    W_BYTE   = 2'd0,
    W_HALF   = 2'd1,
    W_WORD   = 2'd2,
    W_DOUBLE = 2'd3
  } lsu_width_e;

  typedef enum logic [1:0] {
    FAULT_NONE     = 2'd0,
    FAULT_MISALIGN = 2'd1,
    FAULT_ILLEGAL  = 2'd2
  } lsu_fault_e;

  // operation handed over by the pipeline
  typedef struct packed {
    logic       is_store;
    logic [2:0] funct3;
    word_t      addr;
    word_t      wdata;
  } lsu_req_t;

  // decoded operation, lanes already placed in the doubleword
  typedef struct packed {
    logic       is_store;
    lsu_width_e width;
    logic       is_signed;
    logic [2:0] offset;     // byte offset inside the doubleword
    logic [7:0] lane_mask;
    word_t      aligned_addr;
    word_t      lane_data;
    lsu_fault_e fault;
  } lsu_dec_t;

  typedef struct packed {
    lsu_fault_e fault;
    word_t      rdata;
  } lsu_resp_t;

  // write channel payload
  typedef struct packed {
    word_t      addr;
    word_t      data;
    logic [7:0] mask;
  } mem_wr_t;

endpackage
